//--- hdl/bringup_pkg.sv
// bringup package with shared types, report characters and default constants
`default_nettype none

package bringup_pkg;

	typedef logic [7:0] byte_t; // one uart payload byte

	typedef struct packed {
		logic  write; // one-cycle strobe
		byte_t data;
	} uart_req_t;

	typedef struct packed {
		logic pa_dir;
		logic pd_dir;
		logic va_dir;
		logic vd_dir;
		logic tst_dir;
		logic tst_oe; // active low
	} lvl_dir_t;

	localparam logic LVL_DIR_INPUT = 1'b0; // board to fpga
	localparam logic LVL_OE_ENABLED = 1'b0;

	localparam byte_t CHAR_ZERO = 8'h30; // ascii '0'
	localparam byte_t CHAR_ONE = 8'h31; // ascii '1'
	localparam byte_t CHAR_EOL = 8'h0a; // line feed

	localparam int DEF_N_PINS = 16;
	localparam int DEF_CLOCKS_PER_BAUD = 104; // 115200 baud at 12 MHz
	localparam int DEF_CLOCKS_PER_SCAN = 1200000; // 10 Hz at 12 MHz
	localparam int DEF_CLOCKS_PER_TOGGLE = 6000;

endpackage

`default_nettype wire

//--- hdl/bringup_sensor_bank.sv
// sensor bank that synchronizes watched pins and flags each one seen both low and high
`timescale 1ns/1ns
`default_nettype none

module bringup_sensor_bank import bringup_pkg::*; #(
	parameter int N_PINS = DEF_N_PINS
) (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic [N_PINS-1:0] pins_i,
	input  logic              clear_i,
	output logic [N_PINS-1:0] sensed_o
);

	logic [N_PINS-1:0] sync1_q, sync2_q; // two-flop synchronizer
	logic [N_PINS-1:0] seen_low_q, seen_high_q;

	always_ff @(posedge clock_i) begin
		sync1_q <= pins_i;
		sync2_q <= sync1_q;
	end

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			seen_low_q <= '0;
			seen_high_q <= '0;
		end else if (clear_i) begin
			seen_low_q <= '0; // level seen this cycle is dropped
			seen_high_q <= '0;
		end else begin
			seen_low_q <= seen_low_q | ~sync2_q;
			seen_high_q <= seen_high_q | sync2_q;
		end
	end

	assign sensed_o = seen_low_q & seen_high_q; // both levels since last clear

endmodule

`default_nettype wire

//--- hdl/pulse.sv
// pulse generator giving a one-cycle pulse at a fixed period from a free-running down-counter
`timescale 1ns/1ns
`default_nettype none

module pulse import bringup_pkg::*; #(
	parameter int CLOCKS_PER_PULSE = DEF_CLOCKS_PER_SCAN
) (
	input  logic clock_i,
	input  logic rst_n_i,
	output logic pulse_o
);

	localparam int CW = $clog2(CLOCKS_PER_PULSE + 1);
	localparam logic [CW-1:0] RELOAD = CW'(CLOCKS_PER_PULSE - 1);

	logic [CW-1:0] count_q;

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			count_q <= RELOAD;
			pulse_o <= 1'b0;
		end else if (count_q == '0) begin
			count_q <= RELOAD; // reload and fire
			pulse_o <= 1'b1;
		end else begin
			count_q <= count_q - 1'b1;
			pulse_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/bringup_driver.sv
// loopback driver making a square wave on one pin for the board loopback check
`timescale 1ns/1ns
`default_nettype none

module bringup_driver import bringup_pkg::*; #(
	parameter int CLOCKS_PER_TOGGLE = DEF_CLOCKS_PER_TOGGLE
) (
	input  logic clock_i,
	input  logic rst_n_i,
	output logic pin_o
);

	localparam int CW = $clog2(CLOCKS_PER_TOGGLE + 1);
	localparam logic [CW-1:0] LAST = CW'(CLOCKS_PER_TOGGLE - 1);

	logic [CW-1:0] count_q;

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			count_q <= '0;
			pin_o <= 1'b0;
		end else if (count_q == LAST) begin
			count_q <= '0;
			pin_o <= ~pin_o; // half period done
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
// uart transmitter for 8N1 serial output with a busy level
`timescale 1ns/1ns
`default_nettype none

module uart_tx import bringup_pkg::*; #(
	parameter int CLOCKS_PER_BAUD = DEF_CLOCKS_PER_BAUD
) (
	input  logic      clock_i,
	input  logic      rst_n_i,
	input  uart_req_t req_i,
	output logic      busy_o,
	output logic      tx_o
);

	localparam int BW = $clog2(CLOCKS_PER_BAUD + 1);
	localparam logic [BW-1:0] BAUD_LAST = BW'(CLOCKS_PER_BAUD - 1);
	localparam logic [3:0] LAST_BIT = 4'd9; // 8 data bits plus stop

	logic [BW-1:0] baud_cnt_q;
	logic [3:0]    bit_cnt_q;
	logic [8:0]    shift_q; // data with stop bit on top

	// writes are trusted to arrive only while idle
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			busy_o <= 1'b0;
			tx_o <= 1'b1; // line idles high
			bit_cnt_q <= '0;
			baud_cnt_q <= '0;
		end else if (req_i.write) begin
			busy_o <= 1'b1;
			tx_o <= 1'b0; // start bit
			bit_cnt_q <= '0;
			baud_cnt_q <= BAUD_LAST;
		end else if (busy_o) begin
			if (baud_cnt_q != '0) begin
				baud_cnt_q <= baud_cnt_q - 1'b1;
			end else if (bit_cnt_q == LAST_BIT) begin
				busy_o <= 1'b0; // stop bit finished
			end else begin
				tx_o <= shift_q[0];
				bit_cnt_q <= bit_cnt_q + 1'b1;
				baud_cnt_q <= BAUD_LAST;
			end
		end
	end

	// payload shifter sends lsb first
	always_ff @(posedge clock_i) begin
		if (req_i.write) begin
			shift_q <= {1'b1, req_i.data};
		end else if (busy_o && baud_cnt_q == '0) begin
			shift_q <= {1'b1, shift_q[8:1]};
		end
	end

endmodule

`default_nettype wire

//--- hdl/bringup_scanner.sv
// report scanner that snapshots sensor flags on a scan pulse and sends them as ascii
`timescale 1ns/1ns
`default_nettype none

module bringup_scanner import bringup_pkg::*; #(
	parameter int N_PINS = DEF_N_PINS
) (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic              pulse_i,
	input  logic [N_PINS-1:0] state_i,
	input  logic              busy_i,
	output logic              clear_o,
	output uart_req_t         req_o
);

	localparam int IW = (N_PINS > 1) ? $clog2(N_PINS) : 1;

	typedef logic [IW-1:0] pin_idx_t;
	typedef enum logic [1:0] {
		IDLE,
		SEND_PIN,
		WAIT_PIN,
		SEND_EOL
	} state_t;

	localparam pin_idx_t LAST_PIN = IW'(N_PINS - 1);

	state_t            state_q;
	pin_idx_t          idx_q;
	logic [N_PINS-1:0] capture_q;

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			idx_q <= '0;
			clear_o <= 1'b0;
		end else begin
			clear_o <= (state_q == IDLE) && pulse_i; // pulses mid-frame are ignored
			case (state_q)
				IDLE: if (pulse_i) begin
					idx_q <= '0;
					state_q <= SEND_PIN;
				end
				SEND_PIN: if (!busy_i) state_q <= WAIT_PIN;
				WAIT_PIN: if (!busy_i) begin // byte done
					if (idx_q == LAST_PIN) begin
						state_q <= SEND_EOL;
					end else begin
						idx_q <= idx_q + 1'b1;
						state_q <= SEND_PIN;
					end
				end
				SEND_EOL: if (!busy_i) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (state_q == IDLE && pulse_i) capture_q <= state_i; // snapshot
	end

	// write strobe only while the transmitter is idle
	assign req_o.write = (state_q == SEND_PIN || state_q == SEND_EOL) && !busy_i;
	assign req_o.data = (state_q == SEND_EOL) ? CHAR_EOL :
		(capture_q[idx_q] ? CHAR_ONE : CHAR_ZERO);

endmodule

`default_nettype wire

//--- hdl/bringup_levelshifter.sv
// level shifter bring-up top with pin sensing, uart report, loopback driver and direction pins
`timescale 1ns/1ns
`default_nettype none

module bringup_levelshifter import bringup_pkg::*; #(
	parameter int N_PINS = DEF_N_PINS,
	parameter int CLOCKS_PER_BAUD = DEF_CLOCKS_PER_BAUD,
	parameter int CLOCKS_PER_SCAN = DEF_CLOCKS_PER_SCAN,
	parameter int CLOCKS_PER_TOGGLE = DEF_CLOCKS_PER_TOGGLE
) (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic [N_PINS-1:0] pins_i, // sensable pins only
	output logic              drive_o, // looped back on the board
	output logic              uart_tx_o,
	output lvl_dir_t          lvl_dir_o
);

	logic              scan_pulse;
	logic              sensor_clear;
	logic [N_PINS-1:0] sensor_state;
	uart_req_t         uart_req;
	logic              uart_busy;

	bringup_driver #(.CLOCKS_PER_TOGGLE(CLOCKS_PER_TOGGLE)) bringup_driver0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.pin_o(drive_o)
	);

	bringup_sensor_bank #(.N_PINS(N_PINS)) bringup_sensor_bank0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.pins_i(pins_i),
		.clear_i(sensor_clear),
		.sensed_o(sensor_state)
	);

	pulse #(.CLOCKS_PER_PULSE(CLOCKS_PER_SCAN)) pulse0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.pulse_o(scan_pulse)
	);

	bringup_scanner #(.N_PINS(N_PINS)) bringup_scanner0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.pulse_i(scan_pulse),
		.state_i(sensor_state),
		.busy_i(uart_busy),
		.clear_o(sensor_clear),
		.req_o(uart_req)
	);

	uart_tx #(.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)) uart_tx0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.req_i(uart_req),
		.busy_o(uart_busy),
		.tx_o(uart_tx_o)
	);

	// all bidirectional shifters held as inputs
	assign lvl_dir_o = '{
		pa_dir:  LVL_DIR_INPUT,
		pd_dir:  LVL_DIR_INPUT,
		va_dir:  LVL_DIR_INPUT,
		vd_dir:  LVL_DIR_INPUT,
		tst_dir: LVL_DIR_INPUT,
		tst_oe:  LVL_OE_ENABLED
	};

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// testbench clock and reset source with a free-running clock and reset held low at start
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clock_o,
	output logic rst_n_o
);

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD_NS / 2) clock_o = ~clock_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		@(negedge clock_o); // release away from the active edge
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/tb_bringup.sv
// bring-up testbench with random pin stimulus, serial report receiver and checks
`timescale 1ns/1ns
`default_nettype none

module tb_bringup import bringup_pkg::*; ();

	localparam int N_PINS = 16;
	localparam int BAUD = 4;
	localparam int SCAN = 1000;
	localparam int TOGGLE = 7;
	localparam int PERIOD_NS = 40;
	localparam int RESET_CYCLES = 16;
	localparam int N_FRAMES = 5;
	localparam int WIN_START = 20; // toggle window inside a scan period
	localparam int WIN_END = 940;
	localparam int MIN_HOLD = 3;
	localparam int TIMEOUT_NS = (RESET_CYCLES + 6 * SCAN + 200) * PERIOD_NS;
	localparam logic [5:0] EXP_DIR = {{5{LVL_DIR_INPUT}}, LVL_OE_ENABLED};

	logic              clk;
	logic              rst_n;
	logic [N_PINS-2:0] stim; // pins 0 to 14
	logic              loop_q = 1'b0; // drive_o back onto pin 15
	logic              drive;
	logic              tx;
	lvl_dir_t          lvl_dir;
	integer            seed;
	int                cyc = 0; // cycles since reset release
	int                frame_count = 0;
	int                frame_len = 0;
	int                check_count = 0;
	int                error_count = 0;
	int                since = 0;
	logic              drive_last = 1'b0;
	logic              drive_seen = 1'b0;
	int                errs [1:6];
	int                frame_test [1:N_FRAMES];
	logic [N_PINS-2:0] exp_mask [1:N_FRAMES];
	byte_t             frame_buf [0:N_PINS-1];

	tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clock_gen0 (
		.clock_o(clk),
		.rst_n_o(rst_n)
	);

	bringup_levelshifter #(
		.N_PINS(N_PINS),
		.CLOCKS_PER_BAUD(BAUD),
		.CLOCKS_PER_SCAN(SCAN),
		.CLOCKS_PER_TOGGLE(TOGGLE)
	) dut0 (
		.clock_i(clk),
		.rst_n_i(rst_n),
		.pins_i({loop_q, stim}),
		.drive_o(drive),
		.uart_tx_o(tx),
		.lvl_dir_o(lvl_dir)
	);

	task automatic note_error(input int t);
		errs[t]++;
		error_count++;
	endtask

	task automatic report_test(input int t);
		string name;
		case (t)
			1: name = "idle line and direction pins";
			2: name = "byte and frame format";
			3: name = "static pins read zero";
			4: name = "toggled pins read one";
			5: name = "capture clears flags";
			default: name = "loopback driver";
		endcase
		if (errs[t] == 0) $display("test %0d %s: ok", t, name);
		else $display("test %0d %s: FAILED with %0d errors", t, name, errs[t]);
	endtask

	// compare a finished frame against the pins toggled in its period
	task automatic check_frame();
		int k;
		int i;
		byte_t want;
		k = frame_count + 1;
		if (k <= N_FRAMES && frame_len == N_PINS) begin
			for (i = 0; i < N_PINS; i++) begin
				want = (i == N_PINS - 1 || exp_mask[k][i]) ? CHAR_ONE : CHAR_ZERO;
				check_count++;
				assert (frame_buf[i] == want) else begin
					$display("MISMATCH %0t: frame %0d pin %0d got %h, expected %h",
						$time, k, i, frame_buf[i], want);
					note_error((i == N_PINS - 1) ? 6 : frame_test[k]);
				end
			end
		end
		frame_count = k;
		if (k == 1) report_test(3);
		if (k == 4) report_test(4);
		if (k == 5) report_test(5);
	endtask

	task automatic take_byte(input byte_t b);
		check_count++;
		if (b == CHAR_EOL) begin
			assert (frame_len == N_PINS) else begin
				$display("MISMATCH %0t: frame of %0d characters, expected %0d",
					$time, frame_len, N_PINS);
				note_error(2);
			end
			check_frame();
			frame_len = 0;
		end else begin
			assert (b == CHAR_ZERO || b == CHAR_ONE) else begin
				$display("MISMATCH %0t: unexpected report character %h", $time, b);
				note_error(2);
			end
			if (frame_len < N_PINS) frame_buf[frame_len] = b;
			frame_len++;
		end
	endtask

	// toggle the chosen pins inside scan period k with levels held a few cycles
	task automatic run_period(input int k, input logic [N_PINS-2:0] subset);
		int i;
		int hold [0:N_PINS-2];
		while (cyc < k * SCAN + WIN_START) @(negedge clk);
		for (i = 0; i < N_PINS - 1; i++) hold[i] = $random(seed) & 7;
		while (cyc < k * SCAN + WIN_END) begin
			for (i = 0; i < N_PINS - 1; i++) begin
				if (subset[i] && hold[i] == 0) begin
					stim[i] = ~stim[i];
					hold[i] = MIN_HOLD + ($random(seed) & 7);
				end else if (subset[i]) begin
					hold[i]--;
				end
			end
			@(negedge clk);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) cyc <= 0;
		else cyc <= cyc + 1;
	end

	always @(negedge clk) begin
		check_count++;
		assert (lvl_dir === EXP_DIR) else begin
			$display("MISMATCH %0t: lvl_dir_o is %b, expected %b", $time, lvl_dir, EXP_DIR);
			note_error(1);
		end
		if (rst_n && cyc <= SCAN) begin // before the first capture
			assert (tx === 1'b1) else begin
				$display("MISMATCH %0t: uart_tx_o left idle before the first report", $time);
				note_error(1);
			end
		end
	end

	// loopback and toggle interval of the driver pin
	always @(negedge clk) begin
		loop_q <= drive;
		if (rst_n) begin
			since = since + 1;
			if (drive !== drive_last) begin
				if (drive_seen) begin
					check_count++;
					assert (since == TOGGLE) else begin
						$display("MISMATCH %0t: drive_o held %0d cycles, expected %0d",
							$time, since, TOGGLE);
						note_error(6);
					end
				end
				since = 0;
				drive_seen = 1'b1;
			end
			drive_last = drive;
		end
	end

	initial begin : serial_rx
		byte_t rx;
		int i;
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			if (tx === 1'b0) begin
				repeat (BAUD / 2) @(negedge clk); // middle of start bit
				check_count++;
				assert (tx === 1'b0) else begin
					$display("MISMATCH %0t: start bit not low at its middle", $time);
					note_error(2);
				end
				for (i = 0; i < 8; i++) begin
					repeat (BAUD) @(negedge clk);
					rx[i] = tx; // lsb first
				end
				repeat (BAUD) @(negedge clk);
				check_count++;
				assert (tx === 1'b1) else begin
					$display("MISMATCH %0t: stop bit is low", $time);
					note_error(2);
				end
				take_byte(rx);
			end
		end
	end

	initial begin : main
		logic [N_PINS-2:0] subset;
		int t;
		int passed;
		seed = 32'hf8d9;
		stim = $random(seed); // static random levels
		for (t = 1; t <= 6; t++) errs[t] = 0;
		for (t = 1; t <= N_FRAMES; t++) begin
			frame_test[t] = (t == 1) ? 3 : ((t % 2 == 0) ? 4 : 5);
			exp_mask[t] = '0;
		end
		@(posedge rst_n);
		for (t = 0; t < N_FRAMES; t++) begin
			subset = '0;
			if (t % 2 == 1) begin // odd periods toggle and even ones hold still
				subset = $random(seed);
				if (subset == '0) subset[0] = 1'b1;
				exp_mask[t + 1] = subset;
			end
			run_period(t, subset);
		end
		wait (frame_count >= N_FRAMES);
		report_test(1);
		report_test(2);
		report_test(6);
		passed = 0;
		for (t = 1; t <= 6; t++) if (errs[t] == 0) passed++;
		$display("tests run: 6, passed: %0d, failed: %0d, checks: %0d, errors: %0d",
			passed, 6 - passed, check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: the report frames did not all arrive within %0d ns", TIMEOUT_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
hdl/bringup_pkg.sv
hdl/bringup_sensor_bank.sv
hdl/pulse.sv
hdl/bringup_driver.sv
hdl/uart_tx.sv
hdl/bringup_scanner.sv
hdl/bringup_levelshifter.sv
tb/tb_clock_gen.sv
tb/tb_bringup.sv

//--- Bender.yml
package:
  name: bringup_levelshifter

sources:
  - files:
      - hdl/bringup_pkg.sv
      - hdl/bringup_sensor_bank.sv
      - hdl/pulse.sv
      - hdl/bringup_driver.sv
      - hdl/uart_tx.sv
      - hdl/bringup_scanner.sv
      - hdl/bringup_levelshifter.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_bringup.sv
